// ==== sim.f ====
design/conv_dw_pkg.sv
design/conv_dw_stage.sv
design/lrelu_stage.sv
design/axis_skid_slice.sv
design/conv_dw_bank.sv
sim/conv_dw_bank_assert.sv
sim/conv_dw_bank_tb.sv

// ==== Makefile ====
# Verilator build and run for the width-conversion bank

VERILATOR ?= verilator
TOP       ?= conv_dw_bank_tb
RTL_TOP   ?= conv_dw_bank
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/conv_dw_bank_tb.sv ====
`timescale 1ns/1ps

module conv_dw_bank_tb;

  import conv_dw_pkg::*;

  localparam int MEMBERS        = 4;
  localparam int UNITS          = 2;
  localparam int N_ENTRIES      = 12;
  localparam int FIRST_LATENCY  = 4;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * MEMBERS * 4 + 100;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   s_valid;
  logic                                   s_ready;
  acc_word_t  [MEMBERS-1:0][UNITS-1:0]    s_data;
  logic       [MEMBERS-1:0]               s_keep;
  lrelu_cfg_t [MEMBERS-1:0]               s_cfg;
  logic                                   s_last;
  logic                                   m_valid;
  logic                                   m_ready;
  acc_word_t  [UNITS-1:0]                 m_data;
  lrelu_cfg_t                             m_cfg;
  logic                                   m_last;

  // Stimulus table with one row per input beat
  acc_word_t  [MEMBERS-1:0][UNITS-1:0] tbl_data  [N_ENTRIES];
  logic       [MEMBERS-1:0]            tbl_keep  [N_ENTRIES];
  lrelu_cfg_t [MEMBERS-1:0]            tbl_cfg   [N_ENTRIES];
  logic                                tbl_last  [N_ENTRIES];
  int                                  tbl_beats [N_ENTRIES];  // Kept members per row

  acc_word_t [UNITS-1:0] exp_data_q [$];
  lrelu_cfg_t            exp_cfg_q  [$];
  logic                  exp_last_q [$];

  int   cycle;
  int   errors;
  int   checks;
  int   out_count;
  int   exp_total;
  int   in_xfer_cycle;
  logic stall_en;

  conv_dw_bank dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .s_cfg   (s_cfg),
    .s_last  (s_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_cfg   (m_cfg),
    .m_last  (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // Negative words shrink by the member's shift when enabled
  function automatic acc_word_t leaky(input acc_word_t w, input lrelu_cfg_t c);
    logic [2:0] sh;
    sh = c[2:0];
    if (c[3] && w[ACC_WIDTH-1]) begin
      return w >>> sh;
    end
    return w;
  endfunction

  task automatic set_row(input int idx, input logic [MEMBERS-1:0] keep,
                         input logic [MEMBERS*4-1:0] cfg, input logic last,
                         input acc_word_t base, input int beats);
    for (int m = 0; m < MEMBERS; m++) begin
      tbl_cfg[idx][m] = cfg[m*4 +: 4];
      for (int u = 0; u < UNITS; u++) begin
        tbl_data[idx][m][u] = base + acc_word_t'((m * UNITS + u) * 'h1111);
      end
    end
    tbl_keep[idx]  = keep;
    tbl_last[idx]  = last;
    tbl_beats[idx] = beats;
  endtask

  task automatic load_table();
    set_row(0,  4'hF, 16'h0000, 1'b0, 24'h001000, 4);  // Plain pass and latency
    set_row(1,  4'hF, 16'h0000, 1'b1, 24'hFFE000, 4);  // Negatives with relu off
    set_row(2,  4'hF, 16'hFA91, 1'b0, 24'hFF8000, 4);
    set_row(3,  4'hF, 16'hCCCC, 1'b1, 24'hFFF000, 4);  // Crosses zero
    set_row(4,  4'h5, 16'h8888, 1'b0, 24'h800000, 2);
    set_row(5,  4'hA, 16'hBBBB, 1'b1, 24'hFFFF00, 2);
    set_row(6,  4'h8, 16'hDEAD, 1'b0, 24'hC00000, 1);
    set_row(7,  4'h0, 16'hFFFF, 1'b0, 24'h123456, 0);  // Nothing kept
    set_row(8,  4'hF, 16'h9F1E, 1'b1, 24'hFFC123, 4);
    set_row(9,  4'hE, 16'hEEEE, 1'b0, 24'h7FF000, 3);
    set_row(10, 4'h9, 16'hA5A5, 1'b1, 24'hFF0000, 2);
    set_row(11, 4'hF, 16'hF0F0, 1'b1, 24'hFFFEEE, 4);
  endtask

  // Reference model with one expected beat per kept member in index order
  task automatic build_expected();
    acc_word_t [UNITS-1:0] d;
    for (int i = 0; i < N_ENTRIES; i++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (tbl_keep[i][m]) begin
          for (int u = 0; u < UNITS; u++) begin
            d[u] = leaky(tbl_data[i][m][u], tbl_cfg[i][m]);
          end
          exp_data_q.push_back(d);
          exp_cfg_q.push_back(tbl_cfg[i][m]);
          exp_last_q.push_back(tbl_last[i] && (m == MEMBERS - 1));
        end
      end
      exp_total += tbl_beats[i];
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("ERROR: run timed out after %0d cycles, %0d expected beats never arrived",
               cycle, exp_data_q.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (stall_en) begin
      m_ready = ($urandom_range(99) >= 30);  // Low about 30% of the time
    end else begin
      m_ready = 1'b1;
    end
  end

  // Output monitor
  always @(posedge clk) begin
    if (rst_n && m_valid && m_ready) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("ERROR: output beat %0d arrived with no expected beat left", out_count);
      end else begin
        if (out_count == 0) begin
          check_value("first_beat_latency", 64'(cycle - in_xfer_cycle), 64'(FIRST_LATENCY));
        end
        check_value("m_data", 64'(m_data), 64'(exp_data_q.pop_front()));
        check_value("m_cfg", 64'(m_cfg), 64'(exp_cfg_q.pop_front()));
        check_value("m_last", 64'(m_last), 64'(exp_last_q.pop_front()));
      end
      out_count++;
    end
  end

  initial begin
    void'($urandom(93581));
    rst_n     = 1'b0;
    s_valid   = 1'b0;
    s_data    = '0;
    s_keep    = '0;
    s_cfg     = '0;
    s_last    = 1'b0;
    m_ready   = 1'b1;
    stall_en  = 1'b0;
    errors    = 0;
    checks    = 0;
    out_count = 0;
    exp_total = 0;
    load_table();
    build_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < N_ENTRIES; i++) begin
      @(negedge clk);
      s_valid = 1'b1;
      s_data  = tbl_data[i];
      s_keep  = tbl_keep[i];
      s_cfg   = tbl_cfg[i];
      s_last  = tbl_last[i];
      do begin
        @(posedge clk);
      end while (!s_ready);
      if (i == 0) begin
        in_xfer_cycle = cycle;
      end
      if (i == 3) begin
        stall_en = 1'b1;
      end
    end
    @(negedge clk);
    s_valid = 1'b0;

    while (exp_data_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);  // Catch stray beats

    errors += exp_data_q.size();
    check_value("output_beats", 64'(out_count), 64'(exp_total));
    errors += dut0.u_assert.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut0.u_assert.fail_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/conv_dw_bank_assert.sv ====
`timescale 1ns/1ps

module conv_dw_bank_assert #(
  parameter int MEMBERS = 4,
  parameter int UNITS   = 2
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                s_valid,
  input logic [MEMBERS-1:0]                  s_keep,
  input logic                                s_last,
  input logic                                m_valid,
  input logic                                m_ready,
  input conv_dw_pkg::acc_word_t [UNITS-1:0]  m_data,
  input conv_dw_pkg::lrelu_cfg_t             m_cfg,
  input logic                                m_last
);

  int fail_count = 0;

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else begin
      fail_count++;
      $error("m_valid high while in reset");
    end

  // Stalled output must hold its beat
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_cfg) && $stable(m_last))
    else begin
      fail_count++;
      $error("output beat changed or dropped while stalled");
    end

  a_last_kept: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid && s_last |-> s_keep[MEMBERS-1])
    else begin
      fail_count++;
      $error("input beat with last has its final member dropped");
    end

endmodule

bind conv_dw_bank conv_dw_bank_assert #(.MEMBERS(MEMBERS), .UNITS(UNITS)) u_assert (.*);

// ==== design/conv_dw_bank.sv ====
`timescale 1ns/1ps

module conv_dw_bank #(
  parameter int MEMBERS   = 4,
  parameter int K         = 2,
  parameter int UNITS     = 2,
  parameter bit USE_SLICE = 1
) (
  input  logic                                              clk,
  input  logic                                              rst_n,

  input  logic                                              s_valid,
  output logic                                              s_ready,
  input  conv_dw_pkg::acc_word_t  [MEMBERS-1:0][UNITS-1:0]  s_data,
  input  logic                    [MEMBERS-1:0]             s_keep,
  input  conv_dw_pkg::lrelu_cfg_t [MEMBERS-1:0]             s_cfg,
  input  logic                                              s_last,

  output logic                                              m_valid,
  input  logic                                              m_ready,
  output conv_dw_pkg::acc_word_t  [UNITS-1:0]               m_data,
  output conv_dw_pkg::lrelu_cfg_t                           m_cfg,
  output logic                                              m_last
);

  import conv_dw_pkg::*;

  localparam int SUB_CORES   = MEMBERS / K;
  localparam int SLICE_WIDTH = UNITS * ACC_WIDTH + LRELU_CFG_WIDTH + 1;

  // After the K split, SUB_CORES members per beat
  logic                                  k_valid, k_ready, k_last;
  acc_word_t  [SUB_CORES-1:0][UNITS-1:0] k_data;
  logic       [SUB_CORES-1:0]            k_keep;
  lrelu_cfg_t [SUB_CORES-1:0]            k_cfg;

  // One member per beat
  logic                  sub_valid, sub_ready, sub_keep, sub_last;
  acc_word_t [UNITS-1:0] sub_data;
  lrelu_cfg_t            sub_cfg;

  logic                  act_valid, act_ready, act_last;
  acc_word_t [UNITS-1:0] act_data;
  lrelu_cfg_t            act_cfg;

  generate
    if (K > 1) begin : g_split_k
      conv_dw_stage #(
        .IN_MEMBERS (MEMBERS),
        .RATIO      (K),
        .UNITS      (UNITS)
      ) u_split_k (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .s_keep  (s_keep),
        .s_cfg   (s_cfg),
        .s_last  (s_last),
        .m_valid (k_valid),
        .m_ready (k_ready),
        .m_data  (k_data),
        .m_keep  (k_keep),
        .m_cfg   (k_cfg),
        .m_last  (k_last)
      );
    end else begin : g_no_split_k
      // K of 1 leaves the whole beat for the second split
      assign k_valid = s_valid;
      assign s_ready = k_ready;
      assign k_data  = s_data;
      assign k_keep  = s_keep;
      assign k_cfg   = s_cfg;
      assign k_last  = s_last;
    end
  endgenerate

  conv_dw_stage #(
    .IN_MEMBERS (SUB_CORES),
    .RATIO      (SUB_CORES),
    .UNITS      (UNITS)
  ) u_split_sub (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (k_valid),
    .s_ready (k_ready),
    .s_data  (k_data),
    .s_keep  (k_keep),
    .s_cfg   (k_cfg),
    .s_last  (k_last),
    .m_valid (sub_valid),
    .m_ready (sub_ready),
    .m_data  (sub_data),
    .m_keep  (sub_keep),
    .m_cfg   (sub_cfg),
    .m_last  (sub_last)
  );

  lrelu_stage #(
    .UNITS (UNITS)
  ) u_lrelu (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (sub_valid),
    .s_ready (sub_ready),
    .s_data  (sub_data),
    .s_keep  (sub_keep),
    .s_cfg   (sub_cfg),
    .s_last  (sub_last),
    .m_valid (act_valid),
    .m_ready (act_ready),
    .m_data  (act_data),
    .m_cfg   (act_cfg),
    .m_last  (act_last)
  );

  generate
    if (USE_SLICE) begin : g_slice
      logic [SLICE_WIDTH-1:0] slice_payload;

      axis_skid_slice #(
        .WIDTH (SLICE_WIDTH)
      ) u_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (act_valid),
        .s_ready   (act_ready),
        .s_payload ({act_data, act_cfg, act_last}),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_payload (slice_payload)
      );

      assign {m_data, m_cfg, m_last} = slice_payload;
    end else begin : g_no_slice
      assign m_valid   = act_valid;
      assign act_ready = m_ready;
      assign m_data    = act_data;
      assign m_cfg     = act_cfg;
      assign m_last    = act_last;
    end
  endgenerate

endmodule

// ==== design/axis_skid_slice.sv ====
`timescale 1ns/1ps

module axis_skid_slice #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_payload,

  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_payload
);

  logic [WIDTH-1:0] skid_payload;
  logic             skid_valid;
  logic             skid_valid_nxt;
  logic             m_valid_nxt;
  logic             s_xfer;
  logic             m_free;

  assign s_xfer = s_valid && s_ready;
  assign m_free = m_ready || !m_valid;  // Main register can take a new beat

  always_comb begin
    m_valid_nxt    = m_valid;
    skid_valid_nxt = skid_valid;
    if (m_free) begin
      // Skid drains first; ready was low, so no new input this cycle
      m_valid_nxt    = skid_valid || s_xfer;
      skid_valid_nxt = 1'b0;
    end else if (s_xfer) begin
      skid_valid_nxt = 1'b1;  // Output stalled, park the beat
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b1;
    end else begin
      m_valid    <= m_valid_nxt;
      skid_valid <= skid_valid_nxt;
      s_ready    <= !skid_valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (m_free) begin
      if (skid_valid) begin
        m_payload <= skid_payload;
      end else if (s_xfer) begin
        m_payload <= s_payload;
      end
    end else if (s_xfer) begin
      skid_payload <= s_payload;
    end
  end

endmodule

// ==== design/lrelu_stage.sv ====
`timescale 1ns/1ps

module lrelu_stage #(
  parameter int UNITS = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic                                 s_valid,
  output logic                                 s_ready,
  input  conv_dw_pkg::acc_word_t  [UNITS-1:0]  s_data,
  input  logic                                 s_keep,
  input  conv_dw_pkg::lrelu_cfg_t              s_cfg,
  input  logic                                 s_last,

  output logic                                 m_valid,
  input  logic                                 m_ready,
  output conv_dw_pkg::acc_word_t  [UNITS-1:0]  m_data,
  output conv_dw_pkg::lrelu_cfg_t              m_cfg,
  output logic                                 m_last
);

  import conv_dw_pkg::*;

  acc_word_t [UNITS-1:0] act;
  lrelu_shift_t          shift;
  logic                  lrelu_en;
  logic                  load;

  assign shift    = s_cfg[LRELU_SHIFT_WIDTH-1:0];
  assign lrelu_en = s_cfg[LRELU_EN_BIT];

  assign s_ready = !m_valid || m_ready;
  assign load    = s_valid && s_ready && s_keep;  // Dropped beats are taken but not stored

  // Negative slope as arithmetic shift
  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      if (lrelu_en && s_data[u][ACC_WIDTH-1]) begin
        act[u] = $signed(s_data[u]) >>> shift;
      end else begin
        act[u] = s_data[u];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid && s_keep;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_data <= act;
      m_cfg  <= s_cfg;
      m_last <= s_last;
    end
  end

endmodule

// ==== design/conv_dw_stage.sv ====
`timescale 1ns/1ps

module conv_dw_stage #(
  parameter  int IN_MEMBERS  = 4,
  parameter  int RATIO       = 2,
  parameter  int UNITS       = 2,
  localparam int OUT_MEMBERS = IN_MEMBERS / RATIO
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,

  input  logic                                                   s_valid,
  output logic                                                   s_ready,
  input  conv_dw_pkg::acc_word_t  [IN_MEMBERS-1:0][UNITS-1:0]    s_data,
  input  logic                    [IN_MEMBERS-1:0]               s_keep,
  input  conv_dw_pkg::lrelu_cfg_t [IN_MEMBERS-1:0]               s_cfg,
  input  logic                                                   s_last,

  output logic                                                   m_valid,
  input  logic                                                   m_ready,
  output conv_dw_pkg::acc_word_t  [OUT_MEMBERS-1:0][UNITS-1:0]   m_data,
  output logic                    [OUT_MEMBERS-1:0]              m_keep,
  output conv_dw_pkg::lrelu_cfg_t [OUT_MEMBERS-1:0]              m_cfg,
  output logic                                                   m_last
);

  import conv_dw_pkg::*;

  localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  typedef enum logic {
    ST_EMPTY,
    ST_HOLD
  } state_t;

  state_t state;
  logic [CNT_W-1:0] cnt;  // Piece currently on the output

  // Held input beat
  acc_word_t  [IN_MEMBERS-1:0][UNITS-1:0] hold_data;
  logic       [IN_MEMBERS-1:0]            hold_keep;
  lrelu_cfg_t [IN_MEMBERS-1:0]            hold_cfg;
  logic                                   hold_last;

  logic last_piece;
  logic load;

  assign last_piece = (cnt == CNT_W'(RATIO - 1));
  assign m_valid    = (state == ST_HOLD);

  // Accept while empty or while the final piece leaves, so beats run back to back
  assign s_ready = (state == ST_EMPTY) || (m_ready && last_piece);
  assign load    = s_valid && s_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_EMPTY;
      cnt   <= '0;
    end else if (load) begin
      state <= ST_HOLD;
      cnt   <= '0;
    end else if (m_valid && m_ready) begin
      if (last_piece) begin
        state <= ST_EMPTY;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hold_data <= s_data;
      hold_keep <= s_keep;
      hold_cfg  <= s_cfg;
      hold_last <= s_last;
    end
  end

  // Piece n carries members n*OUT_MEMBERS upward
  always_comb begin
    for (int o = 0; o < OUT_MEMBERS; o++) begin
      m_data[o] = hold_data[int'(cnt) * OUT_MEMBERS + o];
      m_keep[o] = hold_keep[int'(cnt) * OUT_MEMBERS + o];
      m_cfg[o]  = hold_cfg[int'(cnt) * OUT_MEMBERS + o];
    end
  end

  assign m_last = hold_last && last_piece;  // Only the final piece ends the packet

endmodule

// ==== design/conv_dw_pkg.sv ====
package conv_dw_pkg;

  // Accumulator word as produced by the engine array
  localparam int ACC_WIDTH = 24;

  // Leaky ReLU config is {enable, shift}
  localparam int LRELU_SHIFT_WIDTH = 3;
  localparam int LRELU_CFG_WIDTH   = LRELU_SHIFT_WIDTH + 1;
  localparam int LRELU_EN_BIT      = LRELU_SHIFT_WIDTH;  // Top bit of cfg

  // One signed accumulator or activation word
  typedef logic signed [ACC_WIDTH-1:0] acc_word_t;

  // Per-member activation configuration
  typedef logic [LRELU_CFG_WIDTH-1:0] lrelu_cfg_t;

  // Negative-slope shift amount
  typedef logic [LRELU_SHIFT_WIDTH-1:0] lrelu_shift_t;

endpackage
